/* src.f */
src/soc_periph_pkg.sv
src/periph_apb_decoder.sv
src/apb_gpio.sv
src/apb_timer_unit.sv
src/apb_wdt.sv
src/fc_event_router.sv
src/soc_peripherals.sv
testbench/tb_clk_gen.sv
testbench/tb_soc_peripherals.sv

/* src/apb_gpio.sv */
// GPIO with edge interrupt
`timescale 1ns/1ps

module apb_gpio #(
    parameter int NGPIO = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  soc_periph_pkg::apb_req_t req_i,
    output soc_periph_pkg::apb_rsp_t rsp_o,
    input  logic [NGPIO-1:0]         gpio_in_i,
    output logic [NGPIO-1:0]         gpio_out_o,
    output logic [NGPIO-1:0]         gpio_dir_o,
    output logic                     irq_o
);

    logic [NGPIO-1:0] dir_q;
    logic [NGPIO-1:0] out_q;
    logic [NGPIO-1:0] irqen_q;
    // two sync stages plus one more flop to see the edge
    logic [NGPIO-1:0] sync1_q;
    logic [NGPIO-1:0] sync2_q;
    logic [NGPIO-1:0] sync3_q;
    logic             irq_q;
    logic             wr_en;
    logic [7:0]       ofs;

    assign ofs   = req_i.paddr[7:0];
    assign wr_en = req_i.psel & req_i.penable & req_i.pwrite;

    //////////////////////////////////////////////////
    // register writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dir_q   <= '0;
            out_q   <= '0;
            irqen_q <= '0;
        end else if (wr_en) begin
            case (ofs)
                soc_periph_pkg::GPIO_DIR_OFS:   dir_q   <= req_i.pwdata[NGPIO-1:0];
                soc_periph_pkg::GPIO_OUT_OFS:   out_q   <= req_i.pwdata[NGPIO-1:0];
                soc_periph_pkg::GPIO_IRQEN_OFS: irqen_q <= req_i.pwdata[NGPIO-1:0];
                // GPIO_IN is read only, other offsets are errors
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // input sync and rising edge detect
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            sync3_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            sync3_q <= sync2_q;
            irq_q   <= |(sync2_q & ~sync3_q & irqen_q);
        end
    end

    // zero wait read path
    always_comb begin
        rsp_o.pready  = 1'b1;
        rsp_o.pslverr = 1'b0;
        rsp_o.prdata  = '0;
        case (ofs)
            soc_periph_pkg::GPIO_DIR_OFS:   rsp_o.prdata = 32'(dir_q);
            soc_periph_pkg::GPIO_OUT_OFS:   rsp_o.prdata = 32'(out_q);
            soc_periph_pkg::GPIO_IN_OFS:    rsp_o.prdata = 32'(sync2_q);
            soc_periph_pkg::GPIO_IRQEN_OFS: rsp_o.prdata = 32'(irqen_q);
            default:                        rsp_o.pslverr = req_i.psel;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign irq_o      = irq_q;

endmodule

/* src/apb_timer_unit.sv */
// Compare timer
`timescale 1ns/1ps

module apb_timer_unit (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  soc_periph_pkg::apb_req_t req_i,
    output soc_periph_pkg::apb_rsp_t rsp_o,
    output logic                     irq_o
);

    logic        en_q;
    logic [31:0] cnt_q;
    logic [31:0] cmp_q;
    logic        irq_q;
    logic        match;
    logic        wr_en;
    logic        load_cnt;
    logic [7:0]  ofs;

    assign ofs      = req_i.paddr[7:0];
    assign wr_en    = req_i.psel & req_i.penable & req_i.pwrite;
    assign load_cnt = wr_en & (ofs == soc_periph_pkg::TMR_VALUE_OFS);
    assign match    = en_q & (cnt_q == cmp_q);

    //////////////////////////////////////////////////
    // control and compare registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q  <= 1'b0;
            cmp_q <= '0;
        end else if (wr_en) begin
            case (ofs)
                soc_periph_pkg::TMR_CTRL_OFS: en_q  <= req_i.pwdata[0];
                soc_periph_pkg::TMR_CMP_OFS:  cmp_q <= req_i.pwdata;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // counter
    //////////////////////////////////////////////////
    // a bus write to VALUE wins over counting
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
            irq_q <= 1'b0;
        end else begin
            irq_q <= match;
            if (load_cnt) begin
                cnt_q <= req_i.pwdata;
            end else if (match) begin
                cnt_q <= '0;
            end else if (en_q) begin
                cnt_q <= cnt_q + 32'd1;
            end
        end
    end

    always_comb begin
        rsp_o.pready  = 1'b1;
        rsp_o.pslverr = 1'b0;
        rsp_o.prdata  = '0;
        case (ofs)
            soc_periph_pkg::TMR_CTRL_OFS:  rsp_o.prdata = {31'b0, en_q};
            soc_periph_pkg::TMR_VALUE_OFS: rsp_o.prdata = cnt_q;
            soc_periph_pkg::TMR_CMP_OFS:   rsp_o.prdata = cmp_q;
            default:                       rsp_o.pslverr = req_i.psel;
        endcase
    end

    // one cycle pulse per compare hit
    assign irq_o = irq_q;

endmodule

/* src/apb_wdt.sv */
// Watchdog timer
`timescale 1ns/1ps

module apb_wdt (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  soc_periph_pkg::apb_req_t req_i,
    output soc_periph_pkg::apb_rsp_t rsp_o,
    output logic                     wdt_reset_o
);

    logic        en_q;
    logic [31:0] reload_q;
    logic [31:0] cnt_q;
    logic        rst_pulse_q;
    logic        wr_en;
    logic        kick_ok;
    logic [7:0]  ofs;

    assign ofs     = req_i.paddr[7:0];
    assign wr_en   = req_i.psel & req_i.penable & req_i.pwrite;
    assign kick_ok = wr_en & (ofs == soc_periph_pkg::WDT_KICK_OFS) &
                     (req_i.pwdata == 32'(soc_periph_pkg::WDT_KICK_KEY));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q        <= 1'b0;
            reload_q    <= '0;
            cnt_q       <= '0;
            rst_pulse_q <= 1'b0;
        end else begin
            rst_pulse_q <= 1'b0;
            if (wr_en && ofs == soc_periph_pkg::WDT_RELOAD_OFS) begin
                reload_q <= req_i.pwdata;
            end
            if (wr_en && ofs == soc_periph_pkg::WDT_CTRL_OFS) begin
                // enabling starts a fresh period
                en_q  <= req_i.pwdata[0];
                cnt_q <= reload_q;
            end else if (en_q) begin
                if (kick_ok) begin
                    cnt_q <= reload_q;
                end else if (cnt_q == '0) begin
                    // expired: fire and start over
                    rst_pulse_q <= 1'b1;
                    cnt_q       <= reload_q;
                end else begin
                    cnt_q <= cnt_q - 32'd1;
                end
            end
        end
    end

    // KICK reads back as zero
    always_comb begin
        rsp_o.pready  = 1'b1;
        rsp_o.pslverr = 1'b0;
        rsp_o.prdata  = '0;
        case (ofs)
            soc_periph_pkg::WDT_CTRL_OFS:   rsp_o.prdata = {31'b0, en_q};
            soc_periph_pkg::WDT_RELOAD_OFS: rsp_o.prdata = reload_q;
            soc_periph_pkg::WDT_KICK_OFS:   rsp_o.prdata = '0;
            default:                        rsp_o.pslverr = req_i.psel;
        endcase
    end

    assign wdt_reset_o = rst_pulse_q;

endmodule

/* src/fc_event_router.sv */
// Fabric controller event router
`timescale 1ns/1ps

module fc_event_router (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        slow_clk_i,
    input  logic        gpio_irq_i,
    input  logic        timer_irq_i,
    input  logic        dma_pe_evt_i,
    input  logic        dma_pe_irq_i,
    input  logic        pf_evt_i,
    input  logic [1:0]  fc_hwpe_events_i,
    output logic [31:0] fc_events_o
);

    logic [2:0]  ref_sync_q;
    logic        ref_rise;
    logic        ref_fall;
    logic [31:0] events_d;
    logic [31:0] events_q;

    // bit 0 takes the slow clock, bits 1 and 2 are the synced history
    assign ref_rise = ref_sync_q[1] & ~ref_sync_q[2];
    assign ref_fall = ~ref_sync_q[1] & ref_sync_q[2];

    always_comb begin
        events_d                               = '0;
        events_d[soc_periph_pkg::EVT_DMA_PE]   = dma_pe_evt_i;
        events_d[soc_periph_pkg::EVT_DMA_IRQ]  = dma_pe_irq_i;
        events_d[soc_periph_pkg::EVT_TIMER_LO] = timer_irq_i;
        events_d[soc_periph_pkg::EVT_PF]       = pf_evt_i;
        events_d[soc_periph_pkg::EVT_REF_CLK]  = ref_rise | ref_fall;
        events_d[soc_periph_pkg::EVT_GPIO]     = gpio_irq_i;
        events_d[soc_periph_pkg::EVT_HWPE0]    = fc_hwpe_events_i[0];
        events_d[soc_periph_pkg::EVT_HWPE1]    = fc_hwpe_events_i[1];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ref_sync_q <= '0;
            events_q   <= '0;
        end else begin
            ref_sync_q <= {ref_sync_q[1:0], slow_clk_i};
            events_q   <= events_d;
        end
    end

    assign fc_events_o = events_q;

endmodule

/* src/periph_apb_decoder.sv */
// Peripheral APB decoder
`timescale 1ns/1ps

module periph_apb_decoder (
    input  soc_periph_pkg::apb_req_t apb_i,
    output soc_periph_pkg::apb_rsp_t apb_o,

    output soc_periph_pkg::apb_req_t gpio_req_o,
    input  soc_periph_pkg::apb_rsp_t gpio_rsp_i,
    output soc_periph_pkg::apb_req_t tmr_req_o,
    input  soc_periph_pkg::apb_rsp_t tmr_rsp_i,
    output soc_periph_pkg::apb_req_t wdt_req_o,
    input  soc_periph_pkg::apb_rsp_t wdt_rsp_i
);

    logic [3:0] slv_idx;

    assign slv_idx = apb_i.paddr[soc_periph_pkg::SLAVE_SEL_LSB +: 4];

    //////////////////////////////////////////////////
    // request fan-out
    //////////////////////////////////////////////////
    // address, data and strobes go to every slave, only psel is steered
    always_comb begin
        gpio_req_o      = apb_i;
        tmr_req_o       = apb_i;
        wdt_req_o       = apb_i;
        gpio_req_o.psel = apb_i.psel & (slv_idx == soc_periph_pkg::SLV_GPIO);
        tmr_req_o.psel  = apb_i.psel & (slv_idx == soc_periph_pkg::SLV_TIMER);
        wdt_req_o.psel  = apb_i.psel & (slv_idx == soc_periph_pkg::SLV_WDT);
    end

    //////////////////////////////////////////////////
    // response mux
    //////////////////////////////////////////////////
    always_comb begin
        case (slv_idx)
            soc_periph_pkg::SLV_GPIO: begin
                apb_o = gpio_rsp_i;
            end
            soc_periph_pkg::SLV_TIMER: begin
                apb_o = tmr_rsp_i;
            end
            soc_periph_pkg::SLV_WDT: begin
                apb_o = wdt_rsp_i;
            end
            default: begin
                // nothing lives here, answer at once with an error
                apb_o.prdata  = '0;
                apb_o.pready  = 1'b1;
                apb_o.pslverr = apb_i.psel;
            end
        endcase
    end

endmodule

/* src/soc_periph_pkg.sv */
// SoC peripheral definitions
package soc_periph_pkg;

    localparam int APB_ADDR_WIDTH = 32;
    localparam int APB_DATA_WIDTH = 32;

    // bus request from master towards a slave
    typedef struct packed {
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [APB_DATA_WIDTH-1:0] pwdata;
        logic                      pwrite;
        logic                      psel;
        logic                      penable;
    } apb_req_t;

    // slave response
    typedef struct packed {
        logic [APB_DATA_WIDTH-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    //////////////////////////////////////////////////
    // address map, paddr[11:8] picks the slave
    //////////////////////////////////////////////////
    localparam int SLAVE_SEL_LSB = 8;

    localparam logic [3:0] SLV_GPIO  = 4'd0;
    localparam logic [3:0] SLV_TIMER = 4'd1;
    localparam logic [3:0] SLV_WDT   = 4'd2;

    localparam logic [7:0] GPIO_DIR_OFS   = 8'h00;
    localparam logic [7:0] GPIO_OUT_OFS   = 8'h04;
    localparam logic [7:0] GPIO_IN_OFS    = 8'h08;
    localparam logic [7:0] GPIO_IRQEN_OFS = 8'h0C;

    localparam logic [7:0] TMR_CTRL_OFS  = 8'h00;
    localparam logic [7:0] TMR_VALUE_OFS = 8'h04;
    localparam logic [7:0] TMR_CMP_OFS   = 8'h08;

    localparam logic [7:0] WDT_CTRL_OFS   = 8'h00;
    localparam logic [7:0] WDT_RELOAD_OFS = 8'h04;
    localparam logic [7:0] WDT_KICK_OFS   = 8'h08;

    // only this value written to KICK reloads the watchdog
    localparam logic [7:0] WDT_KICK_KEY = 8'h5A;

    //////////////////////////////////////////////////
    // fabric controller event positions
    //////////////////////////////////////////////////
    localparam int EVT_DMA_PE   = 8;
    localparam int EVT_DMA_IRQ  = 9;
    localparam int EVT_TIMER_LO = 10;
    localparam int EVT_PF       = 12;
    localparam int EVT_REF_CLK  = 14;
    localparam int EVT_GPIO     = 15;
    localparam int EVT_HWPE0    = 30;
    localparam int EVT_HWPE1    = 31;

endpackage

/* src/soc_peripherals.sv */
// SoC peripheral subsystem top
`timescale 1ns/1ps

module soc_peripherals #(
    parameter int NGPIO = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     slow_clk_i,

    input  soc_periph_pkg::apb_req_t apb_i,
    output soc_periph_pkg::apb_rsp_t apb_o,

    input  logic [NGPIO-1:0]         gpio_in_i,
    output logic [NGPIO-1:0]         gpio_out_o,
    output logic [NGPIO-1:0]         gpio_dir_o,

    input  logic                     dma_pe_evt_i,
    input  logic                     dma_pe_irq_i,
    input  logic                     pf_evt_i,
    input  logic [1:0]               fc_hwpe_events_i,
    output logic [31:0]              fc_events_o,

    output logic                     wdt_reset_o
);

    soc_periph_pkg::apb_req_t gpio_req;
    soc_periph_pkg::apb_rsp_t gpio_rsp;
    soc_periph_pkg::apb_req_t tmr_req;
    soc_periph_pkg::apb_rsp_t tmr_rsp;
    soc_periph_pkg::apb_req_t wdt_req;
    soc_periph_pkg::apb_rsp_t wdt_rsp;
    logic                     gpio_irq;
    logic                     timer_irq;

    //////////////////////////////////////////////////
    // bus decode
    //////////////////////////////////////////////////
    periph_apb_decoder i_periph_dec (
        .apb_i      ( apb_i    ),
        .apb_o      ( apb_o    ),
        .gpio_req_o ( gpio_req ),
        .gpio_rsp_i ( gpio_rsp ),
        .tmr_req_o  ( tmr_req  ),
        .tmr_rsp_i  ( tmr_rsp  ),
        .wdt_req_o  ( wdt_req  ),
        .wdt_rsp_i  ( wdt_rsp  )
    );

    //////////////////////////////////////////////////
    // peripherals
    //////////////////////////////////////////////////
    apb_gpio #(
        .NGPIO ( NGPIO )
    ) i_apb_gpio (
        .clk_i      ( clk_i      ),
        .rst_i      ( rst_i      ),
        .req_i      ( gpio_req   ),
        .rsp_o      ( gpio_rsp   ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .irq_o      ( gpio_irq   )
    );

    apb_timer_unit i_apb_timer_unit (
        .clk_i ( clk_i     ),
        .rst_i ( rst_i     ),
        .req_i ( tmr_req   ),
        .rsp_o ( tmr_rsp   ),
        .irq_o ( timer_irq )
    );

    apb_wdt i_apb_wdt (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .req_i       ( wdt_req     ),
        .rsp_o       ( wdt_rsp     ),
        .wdt_reset_o ( wdt_reset_o )
    );

    // events into the fabric controller
    fc_event_router i_fc_event_router (
        .clk_i            ( clk_i            ),
        .rst_i            ( rst_i            ),
        .slow_clk_i       ( slow_clk_i       ),
        .gpio_irq_i       ( gpio_irq         ),
        .timer_irq_i      ( timer_irq        ),
        .dma_pe_evt_i     ( dma_pe_evt_i     ),
        .dma_pe_irq_i     ( dma_pe_irq_i     ),
        .pf_evt_i         ( pf_evt_i         ),
        .fc_hwpe_events_i ( fc_hwpe_events_i ),
        .fc_events_o      ( fc_events_o      )
    );

endmodule

/* testbench/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // release just after an edge, like any other driven input
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

/* testbench/tb_soc_peripherals.sv */
// Peripheral subsystem testbench
`timescale 1ns/1ps

module tb_soc_peripherals;

    localparam int NGPIO      = 32;
    localparam int TABLE_LEN  = 16;
    localparam int MAX_CYCLES = 20 * TABLE_LEN + 2000;

    // one register access with its expected answer
    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_err;
    } reg_op_t;

    logic                     clk;
    logic                     rst;
    logic                     slow_clk;
    soc_periph_pkg::apb_req_t apb_req;
    soc_periph_pkg::apb_rsp_t apb_rsp;
    logic [NGPIO-1:0]         gpio_in;
    logic [NGPIO-1:0]         gpio_out;
    logic [NGPIO-1:0]         gpio_dir;
    logic                     dma_pe_evt;
    logic                     dma_pe_irq;
    logic                     pf_evt;
    logic [1:0]               hwpe_evt;
    logic [31:0]              fc_events;
    logic                     wdt_reset;

    reg_op_t ops [TABLE_LEN];
    string   op_names [TABLE_LEN];
    int      n_ops = 0;
    integer  seed = 32'haaf5;
    int      cycle_cnt = 0;
    int      wdt_pulses = 0;
    int      wdt_pulse_cycle = 0;
    int      ref_pulses = 0;

    tb_clk_gen #(
        .PERIOD_NS  ( 4.0 ),
        .RST_CYCLES ( 2   )
    ) i_clk_gen (
        .clk_o ( clk ),
        .rst_o ( rst )
    );

    soc_peripherals #(
        .NGPIO ( NGPIO )
    ) uut (
        .clk_i            ( clk        ),
        .rst_i            ( rst        ),
        .slow_clk_i       ( slow_clk   ),
        .apb_i            ( apb_req    ),
        .apb_o            ( apb_rsp    ),
        .gpio_in_i        ( gpio_in    ),
        .gpio_out_o       ( gpio_out   ),
        .gpio_dir_o       ( gpio_dir   ),
        .dma_pe_evt_i     ( dma_pe_evt ),
        .dma_pe_irq_i     ( dma_pe_irq ),
        .pf_evt_i         ( pf_evt     ),
        .fc_hwpe_events_i ( hwpe_evt   ),
        .fc_events_o      ( fc_events  ),
        .wdt_reset_o      ( wdt_reset  )
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] reg_addr(input logic [3:0] slv, input logic [7:0] ofs);
        return (32'(slv) << soc_periph_pkg::SLAVE_SEL_LSB) | 32'(ofs);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // setup then access with the response sampled mid cycle while penable is high
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        next_cycle();
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pwrite  = wr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        next_cycle();
        apb_req.penable = 1'b1;
        @(negedge clk);
        while (apb_rsp.pready !== 1'b1) begin
            @(posedge clk);
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        next_cycle();
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, input string name);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value({name, " pslverr"}, 32'd0, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, input string name);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        check_value({name, " pslverr"}, 32'd0, err);
    endtask

    task automatic add_op(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [31:0] exp_rdata, input logic exp_err, input string name);
        ops[n_ops].wr        = wr;
        ops[n_ops].addr      = addr;
        ops[n_ops].wdata     = wdata;
        ops[n_ops].exp_rdata = exp_rdata;
        ops[n_ops].exp_err   = exp_err;
        op_names[n_ops]      = name;
        n_ops++;
    endtask

    task automatic drive_event(input int idx, input logic val);
        case (idx)
            0: dma_pe_evt  = val;
            1: dma_pe_irq  = val;
            2: pf_evt      = val;
            3: hwpe_evt[0] = val;
            default: hwpe_evt[1] = val;
        endcase
    endtask

    //////////////////////////////////////////////////
    // timeout and pulse monitors
    //////////////////////////////////////////////////
    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    always @(negedge clk) begin
        if (wdt_reset === 1'b1) begin
            if (wdt_pulses == 0) begin
                wdt_pulse_cycle = cycle_cnt;
            end
            wdt_pulses++;
        end
        if (fc_events[soc_periph_pkg::EVT_REF_CLK] === 1'b1) begin
            ref_pulses++;
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin : main_seq
        logic [31:0] gdir;
        logic [31:0] gout;
        logic [31:0] rdata;
        logic        err;
        int          pin;
        int          other;
        int          pulses;
        int          first_hit;
        int          kick_cycle;
        int          k;
        int          evt_bits [5];

        apb_req    = '0;
        gpio_in    = '0;
        slow_clk   = 1'b0;
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        pf_evt     = 1'b0;
        hwpe_evt   = 2'b00;
        evt_bits   = '{soc_periph_pkg::EVT_DMA_PE, soc_periph_pkg::EVT_DMA_IRQ,
                       soc_periph_pkg::EVT_PF, soc_periph_pkg::EVT_HWPE0,
                       soc_periph_pkg::EVT_HWPE1};
        gdir = $random(seed);
        gout = $random(seed);

        // register table of accesses and decode errors followed by read-backs
        add_op(1, reg_addr(4'd0, 8'h00), gdir, 32'd0, 0, "gpio dir write");
        add_op(0, reg_addr(4'd0, 8'h00), 32'd0, gdir, 0, "gpio dir read");
        add_op(1, reg_addr(4'd0, 8'h04), gout, 32'd0, 0, "gpio out write");
        add_op(0, reg_addr(4'd0, 8'h04), 32'd0, gout, 0, "gpio out read");
        add_op(1, reg_addr(4'd1, 8'h08), 32'h1234, 32'd0, 0, "timer cmp write");
        add_op(0, reg_addr(4'd1, 8'h08), 32'd0, 32'h1234, 0, "timer cmp read");
        add_op(1, reg_addr(4'd2, 8'h04), 32'h40, 32'd0, 0, "wdt reload write");
        add_op(0, reg_addr(4'd2, 8'h04), 32'd0, 32'h40, 0, "wdt reload read");
        add_op(1, reg_addr(4'd5, 8'h00), 32'hffff_ffff, 32'd0, 1, "slave 5 write");
        add_op(0, reg_addr(4'd5, 8'h00), 32'd0, 32'd0, 1, "slave 5 read");
        add_op(1, reg_addr(4'd0, 8'h10), 32'hffff_ffff, 32'd0, 1, "gpio 0x10 write");
        add_op(0, reg_addr(4'd0, 8'h10), 32'd0, 32'd0, 1, "gpio 0x10 read");
        add_op(0, reg_addr(4'd0, 8'h00), 32'd0, gdir, 0, "gpio dir kept");
        add_op(0, reg_addr(4'd0, 8'h04), 32'd0, gout, 0, "gpio out kept");
        add_op(0, reg_addr(4'd1, 8'h08), 32'd0, 32'h1234, 0, "timer cmp kept");
        add_op(0, reg_addr(4'd2, 8'h04), 32'd0, 32'h40, 0, "wdt reload kept");

        while (rst !== 1'b0) @(posedge clk);
        #1;
        check_value("reset fc events", 32'd0, fc_events);
        check_value("reset wdt pulse", 32'd0, wdt_reset);
        check_value("reset gpio dir", 32'd0, gpio_dir);
        check_value("reset gpio out", 32'd0, gpio_out);

        for (int i = 0; i < n_ops; i++) begin
            apb_xfer(ops[i].wr, ops[i].addr, ops[i].wdata, rdata, err);
            check_value({op_names[i], " pslverr"}, ops[i].exp_err, err);
            if (!ops[i].wr || ops[i].exp_err) begin
                check_value({op_names[i], " prdata"}, ops[i].exp_rdata, rdata);
            end
        end
        check_value("gpio dir pins", gdir, gpio_dir);
        check_value("gpio out pins", gout, gpio_out);

        // the gpio event bit must rise exactly four cycles after the pin
        pin   = ($random(seed) & 32'h7fff_ffff) % NGPIO;
        other = (pin + 1) % NGPIO;
        apb_write(reg_addr(4'd0, 8'h0C), 32'd1 << pin, "gpio irqen write");
        gpio_in[pin] = 1'b1;
        for (k = 1; k <= 6; k++) begin
            next_cycle();
            @(negedge clk);
            check_value($sformatf("gpio irq pin %0d cycle %0d", pin, k), (k == 4),
                        fc_events[soc_periph_pkg::EVT_GPIO]);
        end
        apb_read(reg_addr(4'd0, 8'h08), rdata, "gpio in read");
        check_value("gpio in value", 32'd1 << pin, rdata);
        gpio_in[other] = 1'b1;
        for (k = 1; k <= 6; k++) begin
            next_cycle();
            @(negedge clk);
            check_value($sformatf("gpio masked pin %0d cycle %0d", other, k), 32'd0,
                        fc_events[soc_periph_pkg::EVT_GPIO]);
        end

        // timer match with compare 20
        apb_write(reg_addr(4'd1, 8'h08), 32'd20, "timer cmp");
        apb_write(reg_addr(4'd1, 8'h04), 32'd0, "timer value load");
        apb_write(reg_addr(4'd1, 8'h00), 32'd1, "timer enable");
        pulses    = 0;
        first_hit = 0;
        for (k = 1; k <= 30; k++) begin
            next_cycle();
            @(negedge clk);
            if (fc_events[soc_periph_pkg::EVT_TIMER_LO] === 1'b1) begin
                pulses++;
                if (first_hit == 0) begin
                    first_hit = k;
                end
            end
        end
        check_value("timer pulse count", 32'd1, pulses);
        check_value("timer pulse in window", 32'd1, (first_hit >= 20) && (first_hit <= 23));
        apb_read(reg_addr(4'd1, 8'h04), rdata, "timer value read");
        check_value("timer value below compare", 32'd1, rdata < 32'd20);
        apb_write(reg_addr(4'd1, 8'h00), 32'd0, "timer disable");

        //////////////////////////////////////////////////
        // watchdog
        //////////////////////////////////////////////////
        apb_write(reg_addr(4'd2, 8'h04), 32'd50, "wdt reload");
        wdt_pulses = 0;
        apb_write(reg_addr(4'd2, 8'h00), 32'd1, "wdt enable");
        repeat (4) begin
            wait_cycles(27);
            apb_write(reg_addr(4'd2, 8'h08), 32'h5A, "wdt kick");
        end
        check_value("wdt quiet while kicked", 32'd0, wdt_pulses);
        kick_cycle = cycle_cnt;
        // a wrong key would push expiry well past the limit
        wait_cycles(17);
        apb_write(reg_addr(4'd2, 8'h08), 32'h33, "wdt wrong key");
        k = 0;
        while (wdt_pulses == 0 && k < 80) begin
            next_cycle();
            k++;
        end
        check_value("wdt pulse after kicks stop", 32'd1, wdt_pulses);
        check_value("wdt pulse within 52 cycles", 32'd1, (wdt_pulse_cycle - kick_cycle) <= 52);
        apb_write(reg_addr(4'd2, 8'h00), 32'd0, "wdt disable");

        // event inputs show up one cycle later at their own bit
        wait_cycles(2);
        for (int i = 0; i < 5; i++) begin
            next_cycle();
            drive_event(i, 1'b1);
            @(negedge clk);
            check_value($sformatf("event bit %0d before", evt_bits[i]), 32'd0, fc_events);
            next_cycle();
            drive_event(i, 1'b0);
            @(negedge clk);
            check_value($sformatf("event bit %0d set", evt_bits[i]), 32'd1 << evt_bits[i],
                        fc_events);
            next_cycle();
            @(negedge clk);
            check_value($sformatf("event bit %0d clear", evt_bits[i]), 32'd0, fc_events);
        end

        // three slow clock periods with two edges each
        next_cycle();
        ref_pulses = 0;
        repeat (6) begin
            slow_clk = ~slow_clk;
            wait_cycles(8);
        end
        check_value("ref clock edge pulses", 32'd6, ref_pulses);

        $display("=== PASS ===");
        $finish;
    end

endmodule
